// File: verilog/cpuCtrlPkg.sv
package cpuCtrlPkg;

    typedef logic [15:0] instr_t;
    typedef logic [3:0]  regIdx_t;
    typedef logic [2:0]  pairIdx_t;           // pair n is registers 2n and 2n+1
    typedef logic [3:0]  aluMode_t;

    localparam aluMode_t AluPassB = 4'd0;
    localparam aluMode_t AluPassA = 4'd13;

    // condition field, instruction bits 15..13
    typedef enum logic [2:0] {
        condAlways   = 3'b000,
        condCarrySet = 3'b001,
        condCarryClr = 3'b010,
        condZeroSet  = 3'b011,
        condZeroClr  = 3'b100,
        condNegSet   = 3'b101,
        condNever    = 3'b110,
        condNegClr   = 3'b111
    } condCode_t;

    typedef enum logic [3:0] {
        clsAluImm, clsAluReg,
        clsIn, clsOut,
        clsStore, clsLoad,
        clsJump, clsCall, clsRet,
        clsHalt, clsNop
    } instrClass_t;

    typedef enum logic [1:0] {pairKeep, pairInc, pairDec} pairStep_t;

    typedef enum logic [4:0] {
        stepIdle, stepAluImm, stepAluReg,
        stepInRead, stepInWrite, stepOut,
        stepStore, stepLoadRead, stepLoadWrite,
        stepJumpTaken, stepJumpTarget, stepSkip,
        stepCallLow, stepCallHigh,
        stepRetLow, stepRetHigh,
        stepNop
    } step_t;

    typedef enum logic {srcBReg, srcBImm8} aluSrcB_t;
    typedef enum logic [1:0] {dataPcHigh = 2'd0, dataPcLow = 2'd1, dataAluOut = 2'd2} dMemData_t;
    typedef enum logic {addrPair, addrDirect} dMemAddr_t;          // direct is {8'd0, instr[11:4]}
    typedef enum logic [1:0] {
        fetchPcPlusOne = 2'b00,
        fetchPcOut     = 2'b01,
        fetchIMemOut   = 2'b11                                     // word just read is the address
    } iMemAddr_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

    typedef struct packed {
        instrClass_t cls;
        logic        condMet;
        pairStep_t   pairStep;
        aluMode_t    aluMode;
        regIdx_t     dstReg;
        regIdx_t     srcReg;
        pairIdx_t    pairIdx;
    } decoded_t;

    typedef struct packed {
        regIdx_t outBSelect;
        logic    writeEn;
        logic    incPair;
        logic    decPair;
    } regCtrl_t;

    typedef struct packed {
        aluSrcB_t srcB;
        aluMode_t mode;
    } aluCtrl_t;

    typedef struct packed {
        dMemData_t dataSel;
        dMemAddr_t addrSel;
        logic      writeEn;
        logic      readEn;
    } dMemCtrl_t;

    typedef struct packed {
        iMemAddr_t addrSel;
        logic      readEn;
        logic      pcWriteEn;
    } fetchCtrl_t;

    typedef struct packed {
        regCtrl_t   regFile;
        aluCtrl_t   alu;
        dMemCtrl_t  dMem;
        fetchCtrl_t fetch;
        logic       flagEnable;
    } ctrlWord_t;

endpackage

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  cpuCtrlPkg::instr_t   instr,
    input  cpuCtrlPkg::flags_t   flags,
    output cpuCtrlPkg::decoded_t decoded
);

    logic [4:0]            opcode;
    logic                  lowZero;
    cpuCtrlPkg::condCode_t cond;

    assign opcode  = instr[7:3];
    assign lowZero = (instr[2:0] == 3'b000);
    assign cond    = cpuCtrlPkg::condCode_t'(instr[15:13]);

    // register fields are taken unconditionally, the encoder picks what it needs
    assign decoded.dstReg  = instr[15:12];
    assign decoded.srcReg  = instr[11:8];
    assign decoded.pairIdx = instr[11:9];

    always_comb begin
        case (cond)
            cpuCtrlPkg::condAlways:   decoded.condMet = 1'b1;
            cpuCtrlPkg::condCarrySet: decoded.condMet = flags.carry;
            cpuCtrlPkg::condCarryClr: decoded.condMet = ~flags.carry;
            cpuCtrlPkg::condZeroSet:  decoded.condMet = flags.zero;
            cpuCtrlPkg::condZeroClr:  decoded.condMet = ~flags.zero;
            cpuCtrlPkg::condNegSet:   decoded.condMet = flags.negative;
            cpuCtrlPkg::condNegClr:   decoded.condMet = ~flags.negative;
            default:                  decoded.condMet = 1'b0;     // 110 never taken
        endcase
    end

    // class priority follows the opcode map, first match wins
    always_comb begin
        decoded.cls      = cpuCtrlPkg::clsNop;
        decoded.pairStep = cpuCtrlPkg::pairKeep;
        decoded.aluMode  = cpuCtrlPkg::AluPassB;
        if (instr[0] && (instr[3:1] != 3'b111)) begin
            decoded.cls     = cpuCtrlPkg::clsAluImm;
            decoded.aluMode = {1'b0, instr[3:1]};
        end else if (instr[2:0] == 3'b010) begin
            decoded.cls = cpuCtrlPkg::clsIn;
        end else if (instr[2:0] == 3'b100) begin
            decoded.cls = cpuCtrlPkg::clsOut;
        end else if (lowZero) begin
            case (opcode)
                5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6,
                5'd7, 5'd8, 5'd9, 5'd10, 5'd11, 5'd12: begin
                    decoded.cls     = cpuCtrlPkg::clsAluReg;
                    decoded.aluMode = instr[6:3];
                end
                5'd13, 5'd14, 5'd15: decoded.cls = cpuCtrlPkg::clsStore;
                5'd16, 5'd17, 5'd18: decoded.cls = cpuCtrlPkg::clsLoad;
                5'd22:               decoded.cls = cpuCtrlPkg::clsJump;
                5'd23:               decoded.cls = cpuCtrlPkg::clsCall;
                5'd24:               decoded.cls = cpuCtrlPkg::clsRet;
                5'd29:               decoded.cls = cpuCtrlPkg::clsHalt;
                default:             decoded.cls = cpuCtrlPkg::clsNop;
            endcase
            // post-access pair step, same layout for store and load
            case (opcode)
                5'd14, 5'd17: decoded.pairStep = cpuCtrlPkg::pairInc;
                5'd15, 5'd18: decoded.pairStep = cpuCtrlPkg::pairDec;
                default:      decoded.pairStep = cpuCtrlPkg::pairKeep;
            endcase
        end
    end

endmodule

// File: verilog/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input  logic                 clk,
    input  logic                 rstN,
    input  cpuCtrlPkg::decoded_t decoded,
    output cpuCtrlPkg::step_t    step
);

    // one state per second cycle of a two-cycle instruction
    typedef enum logic [2:0] {
        stExecute,
        stInWrite,
        stLoadWrite,
        stJumpTarget,
        stCallHigh,
        stRetHigh
    } seqState_t;

    seqState_t         state;
    seqState_t         nextState;
    cpuCtrlPkg::step_t firstStep;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stExecute;
        end else begin
            state <= nextState;
        end
    end

    // step for the first cycle of the current instruction
    always_comb begin
        case (decoded.cls)
            cpuCtrlPkg::clsAluImm: firstStep = cpuCtrlPkg::stepAluImm;
            cpuCtrlPkg::clsAluReg: firstStep = cpuCtrlPkg::stepAluReg;
            cpuCtrlPkg::clsIn:     firstStep = cpuCtrlPkg::stepInRead;
            cpuCtrlPkg::clsOut:    firstStep = cpuCtrlPkg::stepOut;
            cpuCtrlPkg::clsStore:  firstStep = cpuCtrlPkg::stepStore;
            cpuCtrlPkg::clsLoad:   firstStep = cpuCtrlPkg::stepLoadRead;
            cpuCtrlPkg::clsJump: begin
                firstStep = decoded.condMet ? cpuCtrlPkg::stepJumpTaken : cpuCtrlPkg::stepSkip;
            end
            cpuCtrlPkg::clsCall: begin
                firstStep = decoded.condMet ? cpuCtrlPkg::stepCallLow : cpuCtrlPkg::stepSkip;
            end
            cpuCtrlPkg::clsRet: begin
                firstStep = decoded.condMet ? cpuCtrlPkg::stepRetLow : cpuCtrlPkg::stepNop;
            end
            cpuCtrlPkg::clsHalt:   firstStep = cpuCtrlPkg::stepIdle;   // stays until instr changes
            default:               firstStep = cpuCtrlPkg::stepNop;
        endcase
    end

    always_comb begin
        nextState = stExecute;
        case (state)
            stExecute: begin
                step = firstStep;
                case (firstStep)
                    cpuCtrlPkg::stepInRead:    nextState = stInWrite;
                    cpuCtrlPkg::stepLoadRead:  nextState = stLoadWrite;
                    cpuCtrlPkg::stepJumpTaken: nextState = stJumpTarget;
                    cpuCtrlPkg::stepCallLow:   nextState = stCallHigh;
                    cpuCtrlPkg::stepRetLow:    nextState = stRetHigh;
                    default:                   nextState = stExecute;
                endcase
            end
            stInWrite:    step = cpuCtrlPkg::stepInWrite;
            stLoadWrite:  step = cpuCtrlPkg::stepLoadWrite;
            stJumpTarget: step = cpuCtrlPkg::stepJumpTarget;
            stCallHigh:   step = cpuCtrlPkg::stepCallHigh;
            stRetHigh:    step = cpuCtrlPkg::stepRetHigh;
            default:      step = cpuCtrlPkg::stepIdle;
        endcase
        if (!rstN) begin
            step = cpuCtrlPkg::stepIdle;                     // all enables off while in reset
        end
    end

endmodule

// File: verilog/controlWordEncoder.sv
`timescale 1ns/1ps

module controlWordEncoder #(
    parameter cpuCtrlPkg::regIdx_t SpLowReg = 4'd14
) (
    input  cpuCtrlPkg::decoded_t  decoded,
    input  cpuCtrlPkg::step_t     step,
    output cpuCtrlPkg::ctrlWord_t ctrl
);

    cpuCtrlPkg::regIdx_t pairLowReg;
    logic                pairUp;
    logic                pairDown;

    assign pairLowReg = {decoded.pairIdx, 1'b0};             // low byte of the pair
    assign pairUp     = (decoded.pairStep == cpuCtrlPkg::pairInc);
    assign pairDown   = (decoded.pairStep == cpuCtrlPkg::pairDec);

    always_comb begin
        // idle word that each step below modifies
        ctrl.regFile.outBSelect = decoded.dstReg;
        ctrl.regFile.writeEn    = 1'b0;
        ctrl.regFile.incPair    = 1'b0;
        ctrl.regFile.decPair    = 1'b0;
        ctrl.alu.srcB           = cpuCtrlPkg::srcBReg;
        ctrl.alu.mode           = cpuCtrlPkg::AluPassB;
        ctrl.dMem.dataSel       = cpuCtrlPkg::dataAluOut;
        ctrl.dMem.addrSel       = cpuCtrlPkg::addrPair;
        ctrl.dMem.writeEn       = 1'b0;
        ctrl.dMem.readEn        = 1'b0;
        ctrl.fetch.addrSel      = cpuCtrlPkg::fetchPcOut;
        ctrl.fetch.readEn       = 1'b0;
        ctrl.fetch.pcWriteEn    = 1'b0;
        ctrl.flagEnable         = 1'b0;

        // advance unless the step is a hold or idle
        case (step)
            cpuCtrlPkg::stepIdle,
            cpuCtrlPkg::stepInRead,
            cpuCtrlPkg::stepLoadRead,
            cpuCtrlPkg::stepRetLow: ;                        // hold keeps fetch off
            cpuCtrlPkg::stepCallLow: begin
                ctrl.fetch.readEn    = 1'b1;                 // fetch target while PC keeps its value
                ctrl.fetch.pcWriteEn = 1'b0;
            end
            default: begin
                ctrl.fetch.readEn    = 1'b1;
                ctrl.fetch.pcWriteEn = 1'b1;
            end
        endcase

        case (step)
            cpuCtrlPkg::stepAluImm: begin
                ctrl.regFile.writeEn = 1'b1;
                ctrl.alu.srcB        = cpuCtrlPkg::srcBImm8;
                ctrl.alu.mode        = decoded.aluMode;
                ctrl.flagEnable      = 1'b1;
            end
            cpuCtrlPkg::stepAluReg: begin
                ctrl.regFile.outBSelect = decoded.srcReg;
                ctrl.regFile.writeEn    = 1'b1;
                ctrl.alu.mode           = decoded.aluMode;
                ctrl.flagEnable         = 1'b1;
            end
            cpuCtrlPkg::stepInRead: begin
                ctrl.dMem.addrSel = cpuCtrlPkg::addrDirect;
                ctrl.dMem.readEn  = 1'b1;
            end
            cpuCtrlPkg::stepInWrite: begin
                ctrl.dMem.addrSel    = cpuCtrlPkg::addrDirect;
                ctrl.dMem.readEn     = 1'b1;
                ctrl.regFile.writeEn = 1'b1;
            end
            cpuCtrlPkg::stepOut: begin
                ctrl.dMem.addrSel = cpuCtrlPkg::addrDirect;
                ctrl.dMem.writeEn = 1'b1;
            end
            cpuCtrlPkg::stepStore: begin
                ctrl.regFile.outBSelect = pairLowReg;
                ctrl.regFile.incPair    = pairUp;
                ctrl.regFile.decPair    = pairDown;
                ctrl.alu.mode           = cpuCtrlPkg::AluPassA;
                ctrl.dMem.writeEn       = 1'b1;
            end
            cpuCtrlPkg::stepLoadRead: begin
                ctrl.regFile.outBSelect = pairLowReg;
                ctrl.alu.mode           = cpuCtrlPkg::AluPassA;
                ctrl.dMem.readEn        = 1'b1;
            end
            cpuCtrlPkg::stepLoadWrite: begin
                ctrl.regFile.outBSelect = pairLowReg;
                ctrl.regFile.writeEn    = 1'b1;
                ctrl.regFile.incPair    = pairUp;            // pair moves only after the read
                ctrl.regFile.decPair    = pairDown;
                ctrl.alu.mode           = cpuCtrlPkg::AluPassA;
                ctrl.dMem.readEn        = 1'b1;
            end
            cpuCtrlPkg::stepJumpTarget: ctrl.fetch.addrSel = cpuCtrlPkg::fetchIMemOut;
            cpuCtrlPkg::stepSkip:       ctrl.fetch.addrSel = cpuCtrlPkg::fetchPcPlusOne;
            cpuCtrlPkg::stepCallLow,
            cpuCtrlPkg::stepCallHigh: begin
                ctrl.regFile.outBSelect = SpLowReg;
                ctrl.regFile.decPair    = 1'b1;              // push onto a downward stack
                ctrl.dMem.writeEn       = 1'b1;
                if (step == cpuCtrlPkg::stepCallLow) begin
                    ctrl.dMem.dataSel = cpuCtrlPkg::dataPcLow;
                end else begin
                    ctrl.dMem.dataSel  = cpuCtrlPkg::dataPcHigh;
                    ctrl.fetch.addrSel = cpuCtrlPkg::fetchIMemOut;
                end
            end
            cpuCtrlPkg::stepRetLow,
            cpuCtrlPkg::stepRetHigh: begin
                ctrl.regFile.outBSelect = SpLowReg;
                ctrl.regFile.incPair    = 1'b1;              // pop
                ctrl.dMem.readEn        = 1'b1;
                ctrl.fetch.addrSel      = cpuCtrlPkg::fetchIMemOut;
            end
            default: ;                                       // idle, jump taken and nop
        endcase
    end

endmodule

// File: verilog/cpuControl.sv
`timescale 1ns/1ps

module cpuControl #(
    parameter cpuCtrlPkg::regIdx_t SpLowReg = 4'd14         // stack pointer low byte
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  cpuCtrlPkg::instr_t    instr,
    input  cpuCtrlPkg::flags_t    flags,
    output cpuCtrlPkg::ctrlWord_t ctrl
);

    cpuCtrlPkg::decoded_t decoded;
    cpuCtrlPkg::step_t    step;

    instrDecoder uDecoder (
        .instr   (instr),
        .flags   (flags),
        .decoded (decoded)
    );

    controlSequencer uSequencer (
        .clk     (clk),
        .rstN    (rstN),
        .decoded (decoded),
        .step    (step)
    );

    controlWordEncoder #(
        .SpLowReg (SpLowReg)
    ) uEncoder (
        .decoded (decoded),
        .step    (step),
        .ctrl    (ctrl)
    );

endmodule

// File: verif/cpuControlTb.sv
`timescale 1ns/1ps

module cpuControlTb;

    localparam int NumInstr = 400;
    localparam int TimeoutNs = (16 + NumInstr * 2) * 4 * 2;
    localparam cpuCtrlPkg::regIdx_t SpLow = 4'd14;

    logic                      clk = 1'b0;
    logic                      rstN;
    cpuCtrlPkg::instr_t        instr;
    cpuCtrlPkg::flags_t        flags;
    cpuCtrlPkg::ctrlWord_t     ctrl;
    cpuCtrlPkg::ctrlWord_t     expWord;
    cpuCtrlPkg::instrClass_t   curClass;
    cpuCtrlPkg::aluMode_t      curMode;
    cpuCtrlPkg::pairStep_t     curPairStep;
    logic                      curTaken;
    int                        phase;                    // cycle within the instruction
    int                        errCount = 0;

    cpuControl #(.SpLowReg(SpLow)) uut (
        .clk   (clk),
        .rstN  (rstN),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    always #2 clk = ~clk;

    function automatic logic condHolds(input logic [2:0] code, input cpuCtrlPkg::flags_t f);
        case (code)
            3'b000:  return 1'b1;
            3'b001:  return f.carry;
            3'b010:  return !f.carry;
            3'b011:  return f.zero;
            3'b100:  return !f.zero;
            3'b101:  return f.negative;
            3'b111:  return !f.negative;
            default: return 1'b0;                        // 110 never
        endcase
    endfunction

    // expected control word from the step table
    function automatic cpuCtrlPkg::ctrlWord_t refWord(input cpuCtrlPkg::instr_t ins,
            input logic inReset, input cpuCtrlPkg::instrClass_t c,
            input cpuCtrlPkg::aluMode_t m, input cpuCtrlPkg::pairStep_t ps,
            input logic tk, input int ph);
        cpuCtrlPkg::ctrlWord_t w;
        logic                  rd;
        logic                  pcw;
        w = '0;
        w.regFile.outBSelect = ins[15:12];
        w.alu.srcB = cpuCtrlPkg::srcBReg;
        w.alu.mode = cpuCtrlPkg::AluPassB;
        w.dMem.dataSel = cpuCtrlPkg::dataAluOut;
        w.dMem.addrSel = cpuCtrlPkg::addrPair;
        w.fetch.addrSel = cpuCtrlPkg::fetchPcOut;
        rd = !inReset;
        pcw = !inReset;
        if (!inReset) begin
            case (c)
                cpuCtrlPkg::clsAluImm, cpuCtrlPkg::clsAluReg: begin
                    w.regFile.writeEn = 1'b1;
                    w.alu.mode = m;
                    w.flagEnable = 1'b1;
                    if (c == cpuCtrlPkg::clsAluImm) begin
                        w.alu.srcB = cpuCtrlPkg::srcBImm8;
                    end else begin
                        w.regFile.outBSelect = ins[11:8];
                    end
                end
                cpuCtrlPkg::clsIn: begin
                    w.dMem.addrSel = cpuCtrlPkg::addrDirect;
                    w.dMem.readEn = 1'b1;
                    w.regFile.writeEn = (ph == 1);
                    rd = (ph == 1);                          // first cycle holds
                    pcw = (ph == 1);
                end
                cpuCtrlPkg::clsOut: begin
                    w.dMem.addrSel = cpuCtrlPkg::addrDirect;
                    w.dMem.writeEn = 1'b1;
                end
                cpuCtrlPkg::clsStore, cpuCtrlPkg::clsLoad: begin
                    w.regFile.outBSelect = {ins[11:9], 1'b0};
                    w.alu.mode = cpuCtrlPkg::AluPassA;
                    if (c == cpuCtrlPkg::clsStore || ph == 1) begin
                        w.regFile.incPair = (ps == cpuCtrlPkg::pairInc);
                        w.regFile.decPair = (ps == cpuCtrlPkg::pairDec);
                    end
                    if (c == cpuCtrlPkg::clsStore) begin
                        w.dMem.writeEn = 1'b1;
                    end else begin
                        w.dMem.readEn = 1'b1;
                        w.regFile.writeEn = (ph == 1);
                        rd = (ph == 1);
                        pcw = (ph == 1);
                    end
                end
                cpuCtrlPkg::clsJump: begin
                    if (!tk) begin
                        w.fetch.addrSel = cpuCtrlPkg::fetchPcPlusOne;
                    end else if (ph == 1) begin
                        w.fetch.addrSel = cpuCtrlPkg::fetchIMemOut;
                    end
                end
                cpuCtrlPkg::clsCall: begin
                    if (!tk) begin
                        w.fetch.addrSel = cpuCtrlPkg::fetchPcPlusOne;
                    end else begin
                        w.regFile.outBSelect = SpLow;
                        w.regFile.decPair = 1'b1;
                        w.dMem.writeEn = 1'b1;
                        if (ph == 0) begin
                            w.dMem.dataSel = cpuCtrlPkg::dataPcLow;
                            pcw = 1'b0;                      // target fetched, PC kept
                        end else begin
                            w.dMem.dataSel = cpuCtrlPkg::dataPcHigh;
                            w.fetch.addrSel = cpuCtrlPkg::fetchIMemOut;
                        end
                    end
                end
                cpuCtrlPkg::clsRet: begin
                    if (tk) begin
                        w.regFile.outBSelect = SpLow;
                        w.regFile.incPair = 1'b1;
                        w.dMem.readEn = 1'b1;
                        w.fetch.addrSel = cpuCtrlPkg::fetchIMemOut;
                        rd = (ph == 1);
                        pcw = (ph == 1);
                    end
                end
                cpuCtrlPkg::clsHalt: begin
                    rd = 1'b0;
                    pcw = 1'b0;
                end
                default: ;                                   // nop advances
            endcase
        end
        w.fetch.readEn = rd;
        w.fetch.pcWriteEn = pcw;
        return w;
    endfunction

    assign expWord = refWord(instr, !rstN, curClass, curMode, curPairStep, curTaken, phase);

    regFileOk: assert property (@(posedge clk) ctrl.regFile == expWord.regFile) else begin
        errCount++;
        $display("** Error: ctrl.regFile got %h expected %h at %0t",
                 $sampled(ctrl.regFile), $sampled(expWord.regFile), $time);
    end
    aluOk: assert property (@(posedge clk) ctrl.alu == expWord.alu) else begin
        errCount++;
        $display("** Error: ctrl.alu got %h expected %h at %0t",
                 $sampled(ctrl.alu), $sampled(expWord.alu), $time);
    end
    dMemOk: assert property (@(posedge clk) ctrl.dMem == expWord.dMem) else begin
        errCount++;
        $display("** Error: ctrl.dMem got %h expected %h at %0t",
                 $sampled(ctrl.dMem), $sampled(expWord.dMem), $time);
    end
    fetchOk: assert property (@(posedge clk) ctrl.fetch == expWord.fetch) else begin
        errCount++;
        $display("** Error: ctrl.fetch got %h expected %h at %0t",
                 $sampled(ctrl.fetch), $sampled(expWord.fetch), $time);
    end
    flagEnableOk: assert property (@(posedge clk) ctrl.flagEnable == expWord.flagEnable)
    else begin
        errCount++;
        $display("** Error: ctrl.flagEnable got %h expected %h at %0t",
                 $sampled(ctrl.flagEnable), $sampled(expWord.flagEnable), $time);
    end

    // random encoding for a random class
    task automatic pickInstruction();
        logic [7:0] hi;
        logic [4:0] op;
        hi = 8'($urandom);
        op = 5'($urandom);
        curClass = cpuCtrlPkg::instrClass_t'($urandom_range(0, 10));
        curMode = cpuCtrlPkg::AluPassB;
        curPairStep = cpuCtrlPkg::pairKeep;
        case (curClass)
            cpuCtrlPkg::clsAluImm: begin
                curMode = 4'($urandom_range(0, 6));
                instr = {hi, op[3:0], curMode[2:0], 1'b1};
            end
            cpuCtrlPkg::clsIn:  instr = {hi, op, 3'b010};
            cpuCtrlPkg::clsOut: instr = {hi, op, 3'b100};
            cpuCtrlPkg::clsAluReg: begin
                op = 5'($urandom_range(1, 12));
                curMode = op[3:0];
                instr = {hi, op, 3'b000};
            end
            cpuCtrlPkg::clsStore, cpuCtrlPkg::clsLoad: begin
                curPairStep = cpuCtrlPkg::pairStep_t'($urandom_range(0, 2));
                op = (curClass == cpuCtrlPkg::clsStore ? 5'd13 : 5'd16) + 5'(curPairStep);
                instr = {hi, op, 3'b000};
            end
            cpuCtrlPkg::clsJump: instr = {hi, 5'd22, 3'b000};
            cpuCtrlPkg::clsCall: instr = {hi, 5'd23, 3'b000};
            cpuCtrlPkg::clsRet:  instr = {hi, 5'd24, 3'b000};
            cpuCtrlPkg::clsHalt: instr = {hi, 5'd29, 3'b000};
            default: begin
                if (op[0]) begin
                    instr = {hi, op, 3'b110};                // low bits match no class
                end else begin
                    instr = {hi, 5'd30 + 5'(op[1]), 3'b000}; // unused opcodes 30, 31
                end
            end
        endcase
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h8f4a));
        rstN = 1'b0;
        instr = '0;
        flags = '0;
        curClass = cpuCtrlPkg::clsNop;
        curMode = cpuCtrlPkg::AluPassB;
        curPairStep = cpuCtrlPkg::pairKeep;
        curTaken = 1'b0;
        phase = 0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        for (int n = 0; n < NumInstr; n++) begin
            pickInstruction();
            flags = 3'($urandom);
            curTaken = condHolds(instr[15:13], flags);
            case (curClass)
                cpuCtrlPkg::clsIn, cpuCtrlPkg::clsLoad: cycles = 2;
                cpuCtrlPkg::clsJump, cpuCtrlPkg::clsCall, cpuCtrlPkg::clsRet: begin
                    cycles = curTaken ? 2 : 1;
                end
                cpuCtrlPkg::clsHalt: cycles = $urandom_range(1, 2);   // idle while held
                default: cycles = 1;
            endcase
            for (int ph = 0; ph < cycles; ph++) begin
                phase = (curClass == cpuCtrlPkg::clsHalt) ? 0 : ph;
                @(negedge clk);
            end
        end
        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("timeout: stimulus did not finish within %0d ns, errors: %0d",
                 TimeoutNs, errCount);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: compile.f
verilog/cpuCtrlPkg.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/controlWordEncoder.sv
verilog/cpuControl.sv
verif/cpuControlTb.sv

// File: Bender.yml
package:
  name: cpuControl

sources:
  - files:
      - verilog/cpuCtrlPkg.sv
      - verilog/instrDecoder.sv
      - verilog/controlSequencer.sv
      - verilog/controlWordEncoder.sv
      - verilog/cpuControl.sv
  - target: simulation
    files:
      - verif/cpuControlTb.sv
